//--- logic/pong_pkg.sv
// ********************************************************************
// pong package: screen coordinate type, game state and the bundles
// passed between the timing, game and render blocks, plus sprite sizes
// ********************************************************************

package pong_pkg;

    typedef logic [9:0] coord_t;  // screen coordinate

    typedef enum logic {
        IDLE,  // both paddles under computer control
        PLAY   // paddle 1 follows the buttons
    } game_state_e;

    typedef struct packed {
        logic up;        // debounced up level
        logic down;      // debounced down level
        logic ctrl_rel;  // one cycle on control release
    } buttons_t;

    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   hsync;  // active low
        logic   vsync;  // active low
        logic   de;
        logic   frame;  // start of vertical blanking
    } scan_t;

    typedef struct packed {
        coord_t bx;
        coord_t by;
        coord_t p1y;
        coord_t p2y;
    } objects_t;

    typedef struct packed {
        logic ball;
        logic p1;
        logic p2;
    } hits_t;

    localparam coord_t B_SIZE   = 10'd8;   // ball edge
    localparam coord_t P_H      = 10'd40;  // paddle height
    localparam coord_t P_W      = 10'd10;  // paddle width
    localparam coord_t P_SP     = 10'd4;   // paddle step per frame
    localparam coord_t P_OFFS   = 10'd32;  // paddle distance from screen edge
    localparam coord_t BALL_SPX = 10'd6;
    localparam coord_t BALL_SPY = 10'd4;

endpackage

//--- logic/display_timings.sv
// ********************************************************************
// display timings: raster counters with registered syncs, data enable
// and a one-cycle frame strobe at the start of vertical blanking
// ********************************************************************

module display_timings #(
    parameter int H_RES  = 640,
    parameter int V_RES  = 480,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  logic            clk_pix,
    input  logic            arst_n,
    output pong_pkg::scan_t scan
);
    localparam pong_pkg::coord_t H_ACT  = pong_pkg::coord_t'(H_RES);
    localparam pong_pkg::coord_t HS_STA = pong_pkg::coord_t'(H_RES + H_FP);
    localparam pong_pkg::coord_t HS_END = pong_pkg::coord_t'(H_RES + H_FP + H_SYNC);
    localparam pong_pkg::coord_t H_LAST = pong_pkg::coord_t'(H_RES + H_FP + H_SYNC + H_BP - 1);
    localparam pong_pkg::coord_t V_ACT  = pong_pkg::coord_t'(V_RES);
    localparam pong_pkg::coord_t VS_STA = pong_pkg::coord_t'(V_RES + V_FP);
    localparam pong_pkg::coord_t VS_END = pong_pkg::coord_t'(V_RES + V_FP + V_SYNC);
    localparam pong_pkg::coord_t V_LAST = pong_pkg::coord_t'(V_RES + V_FP + V_SYNC + V_BP - 1);

    pong_pkg::coord_t sx_next;
    pong_pkg::coord_t sy_next;

    always_comb begin
        sx_next = scan.sx + 10'd1;
        sy_next = scan.sy;
        if (scan.sx == H_LAST) begin  // end of line
            sx_next = '0;
            sy_next = (scan.sy == V_LAST) ? '0 : scan.sy + 10'd1;
        end
    end

    // flags come from the next position so they line up with sx/sy
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            scan.sx    <= H_LAST;  // first step lands on (0,0)
            scan.sy    <= V_LAST;
            scan.hsync <= 1'b1;
            scan.vsync <= 1'b1;
            scan.de    <= 1'b0;
            scan.frame <= 1'b0;
        end else begin
            scan.sx    <= sx_next;
            scan.sy    <= sy_next;
            scan.hsync <= !(sx_next >= HS_STA && sx_next < HS_END);
            scan.vsync <= !(sy_next >= VS_STA && sy_next < VS_END);
            scan.de    <= (sx_next < H_ACT) && (sy_next < V_ACT);
            scan.frame <= (sx_next == '0) && (sy_next == V_ACT);
        end
    end

endmodule

//--- logic/button_debounce.sv
// ********************************************************************
// button debounce: two-flop sync and stability count per button
// ********************************************************************

module button_debounce #(
    parameter int DEB_CYCLES = 65536
) (
    input  logic               clk_pix,
    input  logic               arst_n,
    input  logic               btn_up,
    input  logic               btn_dn,
    input  logic               btn_ctrl,
    output pong_pkg::buttons_t buttons
);
    localparam int CW = $clog2(DEB_CYCLES + 1);
    localparam logic [CW-1:0] CNT_LAST = CW'(DEB_CYCLES - 1);

    logic [2:0] sync_1;
    logic [2:0] sync_2;
    logic [2:0] level;   // debounced levels: ctrl, dn, up
    logic       ctrl_q;  // previous ctrl level for the release edge

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sync_1 <= '0;
            sync_2 <= '0;
            ctrl_q <= 1'b0;
        end else begin
            sync_1 <= {btn_ctrl, btn_dn, btn_up};
            sync_2 <= sync_1;
            ctrl_q <= level[2];
        end
    end

    for (genvar i = 0; i < 3; i++) begin : g_btn
        logic [CW-1:0] cnt;
        logic          lvl;

        always_ff @(posedge clk_pix or negedge arst_n) begin
            if (!arst_n) begin
                cnt <= '0;
                lvl <= 1'b0;
            end else if (sync_2[i] == lvl) begin
                cnt <= '0;  // agrees again, start over
            end else if (cnt == CNT_LAST) begin
                cnt <= '0;
                lvl <= sync_2[i];
            end else begin
                cnt <= cnt + 1'b1;
            end
        end

        assign level[i] = lvl;
    end

    assign buttons = '{up: level[0], down: level[1], ctrl_rel: ctrl_q & ~level[2]};

endmodule

//--- logic/paddle_control.sv
// ********************************************************************
// paddle control: IDLE/PLAY game state, human paddle 1 in PLAY and
// computer tracking of the ball for the other paddles
// ********************************************************************

module paddle_control #(
    parameter int V_RES = 480
) (
    input  logic                  clk_pix,
    input  logic                  arst_n,
    input  pong_pkg::scan_t       scan,
    input  pong_pkg::buttons_t    buttons,
    input  pong_pkg::coord_t      ball_y,
    output pong_pkg::game_state_e state,
    output pong_pkg::coord_t      p1y,
    output pong_pkg::coord_t      p2y
);
    localparam pong_pkg::coord_t P_RST =
        pong_pkg::coord_t'((V_RES - int'(pong_pkg::P_H)) / 2);
    // lowest top row, shared by the human and the computer paddles
    localparam pong_pkg::coord_t P_MAX =
        pong_pkg::coord_t'(V_RES) - (pong_pkg::P_H + pong_pkg::P_SP);

    // one step toward the ball centre, holding inside the dead band
    function automatic pong_pkg::coord_t track(input pong_pkg::coord_t py,
                                               input pong_pkg::coord_t by);
        pong_pkg::coord_t p_mid;
        pong_pkg::coord_t b_mid;
        p_mid = py + pong_pkg::P_H / 2;
        b_mid = by + pong_pkg::B_SIZE / 2;
        track = py;
        if (p_mid + pong_pkg::P_SP / 2 < b_mid) begin
            if (py < P_MAX) track = py + pong_pkg::P_SP;
        end else if (p_mid > b_mid + pong_pkg::P_SP / 2) begin
            if (py > pong_pkg::P_SP) track = py - pong_pkg::P_SP;
        end
    endfunction

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state <= pong_pkg::IDLE;
        end else if (buttons.ctrl_rel) begin
            case (state)
                pong_pkg::IDLE: state <= pong_pkg::PLAY;
                pong_pkg::PLAY: state <= pong_pkg::IDLE;
                default:        state <= pong_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            p1y <= P_RST;
            p2y <= P_RST;
        end else if (scan.frame) begin
            if (state == pong_pkg::PLAY) begin  // human player
                if (buttons.up && p1y > pong_pkg::P_SP) begin
                    p1y <= p1y - pong_pkg::P_SP;
                end else if (buttons.down && p1y < P_MAX) begin
                    p1y <= p1y + pong_pkg::P_SP;
                end
            end else begin
                p1y <= track(p1y, ball_y);
            end
            p2y <= track(p2y, ball_y);  // always computer
        end
    end

endmodule

//--- logic/ball_motion.sv
// ********************************************************************
// ball motion: per-frame step with wall and paddle bounces
// ********************************************************************

module ball_motion #(
    parameter int H_RES = 640,
    parameter int V_RES = 480
) (
    input  logic             clk_pix,
    input  logic             arst_n,
    input  pong_pkg::scan_t  scan,
    input  pong_pkg::hits_t  hits,
    output pong_pkg::coord_t bx,
    output pong_pkg::coord_t by
);
    localparam pong_pkg::coord_t X_RST = pong_pkg::coord_t'(H_RES / 2);
    localparam pong_pkg::coord_t Y_RST = pong_pkg::coord_t'(V_RES / 2);
    // last positions before the ball would cross the right or bottom wall
    localparam pong_pkg::coord_t X_EDGE =
        pong_pkg::coord_t'(H_RES) - (pong_pkg::BALL_SPX + pong_pkg::B_SIZE);
    localparam pong_pkg::coord_t Y_EDGE =
        pong_pkg::coord_t'(V_RES) - (pong_pkg::BALL_SPY + pong_pkg::B_SIZE);

    logic p1_col;  // ball touched paddle 1 this frame
    logic p2_col;
    logic dx;      // 1 = moving left
    logic dy;      // 1 = moving up

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            p1_col <= 1'b0;
            p2_col <= 1'b0;
        end else if (scan.frame) begin
            p1_col <= 1'b0;
            p2_col <= 1'b0;
        end else if (hits.ball) begin
            if (hits.p1) p1_col <= 1'b1;
            if (hits.p2) p2_col <= 1'b1;
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            bx <= X_RST;
            by <= Y_RST;
            dx <= 1'b0;  // right
            dy <= 1'b0;  // down
        end else if (scan.frame) begin
            if (p1_col) begin
                dx <= 1'b0;
                bx <= bx + pong_pkg::BALL_SPX;
            end else if (p2_col) begin
                dx <= 1'b1;
                bx <= bx - pong_pkg::BALL_SPX;
            end else if (bx >= X_EDGE) begin  // right wall
                dx <= 1'b1;
                bx <= bx - pong_pkg::BALL_SPX;
            end else if (bx < pong_pkg::BALL_SPX) begin  // left wall
                dx <= 1'b0;
                bx <= bx + pong_pkg::BALL_SPX;
            end else begin
                bx <= dx ? bx - pong_pkg::BALL_SPX : bx + pong_pkg::BALL_SPX;
            end

            if (by >= Y_EDGE) begin  // bottom
                dy <= 1'b1;
                by <= by - pong_pkg::BALL_SPY;
            end else if (by < pong_pkg::BALL_SPY) begin
                dy <= 1'b0;
                by <= by + pong_pkg::BALL_SPY;
            end else begin
                by <= dy ? by - pong_pkg::BALL_SPY : by + pong_pkg::BALL_SPY;
            end
        end
    end

endmodule

//--- logic/pixel_render.sv
// ********************************************************************
// pixel render: sprite hit tests and the registered DVI output stage
// ********************************************************************

module pixel_render #(
    parameter int H_RES = 640
) (
    input  logic              clk_pix,
    input  logic              arst_n,
    input  pong_pkg::scan_t   scan,
    input  pong_pkg::objects_t objects,
    output pong_pkg::hits_t   hits,
    output logic              dvi_hsync,
    output logic              dvi_vsync,
    output logic              dvi_de,
    output logic [3:0]        dvi_r,
    output logic [3:0]        dvi_g,
    output logic [3:0]        dvi_b
);
    // paddle 2 columns, mirrored from the right edge
    localparam pong_pkg::coord_t P2_L =
        pong_pkg::coord_t'(H_RES) - pong_pkg::P_OFFS - pong_pkg::P_W;
    localparam pong_pkg::coord_t P2_R = pong_pkg::coord_t'(H_RES) - pong_pkg::P_OFFS;

    logic [3:0] colour;

    always_comb begin
        hits.ball = (scan.sx >= objects.bx) && (scan.sx < objects.bx + pong_pkg::B_SIZE)
                 && (scan.sy >= objects.by) && (scan.sy < objects.by + pong_pkg::B_SIZE);
        hits.p1 = (scan.sx >= pong_pkg::P_OFFS)
               && (scan.sx < pong_pkg::P_OFFS + pong_pkg::P_W)
               && (scan.sy >= objects.p1y) && (scan.sy < objects.p1y + pong_pkg::P_H);
        hits.p2 = (scan.sx >= P2_L) && (scan.sx < P2_R)
               && (scan.sy >= objects.p2y) && (scan.sy < objects.p2y + pong_pkg::P_H);
        colour = (scan.de && (hits.ball || hits.p1 || hits.p2)) ? 4'hf : 4'h0;
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            dvi_hsync <= 1'b1;  // idle high
            dvi_vsync <= 1'b1;
            dvi_de    <= 1'b0;
            dvi_r     <= '0;
            dvi_g     <= '0;
            dvi_b     <= '0;
        end else begin
            dvi_hsync <= scan.hsync;
            dvi_vsync <= scan.vsync;
            dvi_de    <= scan.de;
            dvi_r     <= colour;  // monochrome
            dvi_g     <= colour;
            dvi_b     <= colour;
        end
    end

endmodule

//--- logic/pong_top.sv
// ********************************************************************
// pong top: raster timing, buttons, game logic and renderer
// ********************************************************************

module pong_top #(
    parameter int H_RES      = 640,
    parameter int V_RES      = 480,
    parameter int H_FP       = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BP       = 48,
    parameter int V_FP       = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BP       = 33,
    parameter int DEB_CYCLES = 65536
) (
    input  logic       clk_pix,
    input  logic       arst_n,
    input  logic       btn_up,
    input  logic       btn_dn,
    input  logic       btn_ctrl,
    output logic       dvi_hsync,
    output logic       dvi_vsync,
    output logic       dvi_de,
    output logic [3:0] dvi_r,
    output logic [3:0] dvi_g,
    output logic [3:0] dvi_b
);
    pong_pkg::scan_t       scan;
    pong_pkg::buttons_t    buttons;
    pong_pkg::game_state_e state;
    pong_pkg::coord_t      bx;
    pong_pkg::coord_t      by;
    pong_pkg::coord_t      p1y;
    pong_pkg::coord_t      p2y;
    pong_pkg::objects_t    objects;
    pong_pkg::hits_t       hits;

    assign objects = '{bx: bx, by: by, p1y: p1y, p2y: p2y};

    display_timings #(
        .H_RES(H_RES), .V_RES(V_RES),
        .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_timings (
        .clk_pix(clk_pix),
        .arst_n (arst_n),
        .scan   (scan)
    );

    button_debounce #(.DEB_CYCLES(DEB_CYCLES)) u_debounce (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .btn_up  (btn_up),
        .btn_dn  (btn_dn),
        .btn_ctrl(btn_ctrl),
        .buttons (buttons)
    );

    paddle_control #(.V_RES(V_RES)) u_paddles (
        .clk_pix(clk_pix),
        .arst_n (arst_n),
        .scan   (scan),
        .buttons(buttons),
        .ball_y (by),
        .state  (state),  // observed by the testbench
        .p1y    (p1y),
        .p2y    (p2y)
    );

    ball_motion #(.H_RES(H_RES), .V_RES(V_RES)) u_ball (
        .clk_pix(clk_pix),
        .arst_n (arst_n),
        .scan   (scan),
        .hits   (hits),
        .bx     (bx),
        .by     (by)
    );

    pixel_render #(.H_RES(H_RES)) u_render (
        .clk_pix  (clk_pix),
        .arst_n   (arst_n),
        .scan     (scan),
        .objects  (objects),
        .hits     (hits),
        .dvi_hsync(dvi_hsync),
        .dvi_vsync(dvi_vsync),
        .dvi_de   (dvi_de),
        .dvi_r    (dvi_r),
        .dvi_g    (dvi_g),
        .dvi_b    (dvi_b)
    );

endmodule

//--- tests/pong_assertions.sv
// ********************************************************************
// pong assertions: DVI output stage rules, bound into the renderer
// ********************************************************************

module pong_assertions (
    input logic       clk_pix,
    input logic       arst_n,
    input logic       dvi_vsync,
    input logic       dvi_de,
    input logic [3:0] dvi_r,
    input logic [3:0] dvi_g,
    input logic [3:0] dvi_b
);
    timeunit 1ns;
    timeprecision 100ps;

    // blanking stays black
    dark_in_blanking: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !dvi_de |-> (dvi_r == 4'h0 && dvi_g == 4'h0 && dvi_b == 4'h0))
        else $error("colour output not zero while dvi_de is low");

    no_de_in_vsync: assert property (@(posedge clk_pix) disable iff (!arst_n)
        dvi_de |-> dvi_vsync)
        else $error("dvi_de high during vertical sync");

endmodule

//--- tests/pong_tb.sv
// ********************************************************************
// pong testbench: small screen, frame capture from the DVI stream and
// directed tests for reset, raster, ball, paddles and debounce
// ********************************************************************

module pong_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_RES  = 160;
    localparam int V_RES  = 120;
    localparam int H_FP   = 4;
    localparam int H_SYNC = 8;
    localparam int H_BP   = 8;
    localparam int V_FP   = 2;
    localparam int V_SYNC = 2;
    localparam int V_BP   = 4;
    localparam int DEB    = 16;
    localparam int H_TOT  = H_RES + H_FP + H_SYNC + H_BP;
    localparam int FRAME  = H_TOT * (V_RES + V_FP + V_SYNC + V_BP);
    localparam int B_SIZE = int'(pong_pkg::B_SIZE);
    localparam int P_H    = int'(pong_pkg::P_H);
    localparam int P_W    = int'(pong_pkg::P_W);
    localparam int P_SP   = int'(pong_pkg::P_SP);
    localparam int P_OFFS = int'(pong_pkg::P_OFFS);
    localparam int BALL_L = P_OFFS + P_W;  // ball window between the paddles
    localparam int BALL_R = H_RES - P_OFFS - P_W - 1;

    logic       clk_pix;
    logic       arst_n;
    logic       btn_up;
    logic       btn_dn;
    logic       btn_ctrl;
    logic       dvi_hsync;
    logic       dvi_vsync;
    logic       dvi_de;
    logic [3:0] dvi_r;
    logic [3:0] dvi_g;
    logic [3:0] dvi_b;

    int ball_x;
    int ball_y;
    int p1_top;
    int p2_top;
    int top_row [4];  // first lit row in each paddle edge column

    pong_top #(
        .H_RES(H_RES), .V_RES(V_RES),
        .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .DEB_CYCLES(DEB)
    ) u_dut (
        .clk_pix  (clk_pix),
        .arst_n   (arst_n),
        .btn_up   (btn_up),
        .btn_dn   (btn_dn),
        .btn_ctrl (btn_ctrl),
        .dvi_hsync(dvi_hsync),
        .dvi_vsync(dvi_vsync),
        .dvi_de   (dvi_de),
        .dvi_r    (dvi_r),
        .dvi_g    (dvi_g),
        .dvi_b    (dvi_b)
    );

    bind pixel_render pong_assertions u_assertions (
        .clk_pix  (clk_pix),
        .arst_n   (arst_n),
        .dvi_vsync(dvi_vsync),
        .dvi_de   (dvi_de),
        .dvi_r    (dvi_r),
        .dvi_g    (dvi_g),
        .dvi_b    (dvi_b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #50 clk_pix = ~clk_pix;
    end

    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        stop_on_error();
    endtask

    task automatic expect_eq(input int got, input int exp, input string what);
        assert (got == exp) else begin
            $display("ERR at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // inputs change just after the rising edge
    task automatic clock_wait(input int n);
        repeat (n) @(posedge clk_pix);
        #1;
    endtask

    task automatic apply_reset();
        arst_n   = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
        btn_ctrl = 1'b0;
        clock_wait(8);
        arst_n = 1'b1;
    endtask

    task automatic wait_sync(input bit vert, input logic level, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_pix);
            cycles++;
            if (cycles > 2 * FRAME) timed_out(vert ? "vsync" : "hsync");
        end while ((vert ? dvi_vsync : dvi_hsync) != level);
    endtask

    function automatic int edge_column(input int x);
        if (x == P_OFFS) return 0;
        if (x == P_OFFS + P_W - 1) return 1;
        if (x == H_RES - P_OFFS - P_W) return 2;
        if (x == H_RES - P_OFFS - 1) return 3;
        return -1;
    endfunction

    // position comes from counting de cycles, sampled mid-cycle
    task automatic capture_frame();
        int n;
        int guard;
        int x;
        int y;
        int c;
        n = 0;
        guard = 0;
        ball_x = 1023;
        ball_y = 1023;
        for (int i = 0; i < 4; i++) top_row[i] = 1023;
        while (n < H_RES * V_RES) begin
            @(negedge clk_pix);
            guard++;
            if (guard > 2 * FRAME) timed_out("a full frame of active pixels");
            if (dvi_de) begin
                x = n % H_RES;
                y = n / H_RES;
                expect_eq(int'(dvi_g), int'(dvi_r), "dvi_g against dvi_r");  // monochrome
                expect_eq(int'(dvi_b), int'(dvi_r), "dvi_b against dvi_r");
                if (dvi_r == 4'hf) begin
                    if (x >= BALL_L && x <= BALL_R && x < ball_x) ball_x = x;
                    if (x >= BALL_L && x <= BALL_R && y < ball_y) ball_y = y;
                    c = edge_column(x);
                    if (c >= 0 && y < top_row[c]) top_row[c] = y;
                end
                n++;
            end
        end
        // the ball can cover one edge column of a paddle but never both
        p1_top = (top_row[0] > top_row[1]) ? top_row[0] : top_row[1];
        p2_top = (top_row[2] > top_row[3]) ? top_row[2] : top_row[3];
    endtask

    task automatic next_frame();
        int n;
        wait_sync(1'b1, 1'b0, n);
        capture_frame();
    endtask

    task automatic step_axis(inout int pos, inout bit fwd, input int spd, input int lim);
        if (fwd && pos + spd + B_SIZE > lim) begin
            fwd = 1'b0;
        end else if (!fwd && pos < spd) begin
            fwd = 1'b1;
        end
        pos = fwd ? pos + spd : pos - spd;
    endtask

    // paddle stays at least one step away from the top and bottom
    function automatic int toward_ball(input int p, input int b);
        int p_mid;
        int b_mid;
        p_mid = p + P_H / 2;
        b_mid = b + B_SIZE / 2;
        if (b_mid > p_mid + P_SP / 2) return (p + P_SP + P_H <= V_RES - P_SP) ? p + P_SP : p;
        if (b_mid < p_mid - P_SP / 2) return (p - P_SP >= P_SP) ? p - P_SP : p;
        return p;  // dead band
    endfunction

    task automatic reset_state();
        apply_reset();
        expect_eq(int'(dvi_de), 0, "dvi_de after reset");
        expect_eq(int'({dvi_r, dvi_g, dvi_b}), 0, "colour after reset");
        expect_eq(int'(dvi_hsync), 1, "dvi_hsync after reset");
        expect_eq(int'(dvi_vsync), 1, "dvi_vsync after reset");
        capture_frame();
        expect_eq(ball_x, H_RES / 2, "ball x in first frame");
        expect_eq(ball_y, V_RES / 2, "ball y in first frame");
        expect_eq(p1_top, (V_RES - P_H) / 2, "paddle 1 top row");
        expect_eq(p2_top, (V_RES - P_H) / 2, "paddle 2 top row");
    endtask

    task automatic raster_timing();
        int n;
        int width;
        int cnt;
        int guard;
        wait_sync(1'b0, 1'b1, n);
        wait_sync(1'b0, 1'b0, n);
        wait_sync(1'b0, 1'b1, width);
        expect_eq(width, H_SYNC, "hsync low width");
        wait_sync(1'b0, 1'b0, n);
        expect_eq(width + n, H_TOT, "line period");
        wait_sync(1'b1, 1'b0, n);
        wait_sync(1'b1, 1'b1, n);
        cnt = 0;
        guard = 0;
        while (dvi_vsync) begin  // one whole frame between syncs
            @(negedge clk_pix);
            if (dvi_de) cnt++;
            guard++;
            if (guard > 2 * FRAME) timed_out("the next vsync");
        end
        expect_eq(cnt, H_RES * V_RES, "de cycles per frame");
    endtask

    task automatic idle_motion();
        int bx;
        int by;
        int p2;
        int exp_p2;
        bit right;
        bit down;
        apply_reset();
        capture_frame();
        bx = ball_x;
        by = ball_y;
        p2 = p2_top;
        right = 1'b1;
        down = 1'b1;
        // five frames keep the ball clear of both paddle columns
        for (int k = 1; k <= 5; k++) begin
            exp_p2 = toward_ball(p2, by);
            step_axis(bx, right, int'(pong_pkg::BALL_SPX), H_RES);
            step_axis(by, down, int'(pong_pkg::BALL_SPY), V_RES);
            next_frame();
            expect_eq(ball_x, bx, "ball x");
            expect_eq(ball_y, by, "ball y");
            expect_eq(p2_top, exp_p2, "paddle 2 top row");
            p2 = exp_p2;
        end
    endtask

    task automatic hold_paddle(input bit up);
        int prev;
        int exp;
        int n;
        bit clamped;
        next_frame();
        prev = p1_top;
        wait_sync(1'b1, 1'b0, n);  // just past the frame update
        clock_wait(1);
        btn_up = up;
        btn_dn = !up;
        next_frame();
        expect_eq(p1_top, prev, "paddle 1 before the button takes effect");
        clamped = 1'b0;
        for (int i = 0; i < 30 && !clamped; i++) begin
            if (up) exp = (prev - P_SP >= P_SP) ? prev - P_SP : prev;
            else exp = (prev + P_SP + P_H <= V_RES - P_SP) ? prev + P_SP : prev;
            next_frame();
            expect_eq(p1_top, exp, up ? "paddle 1 moving up" : "paddle 1 moving down");
            clamped = (exp == prev);
            prev = exp;
        end
        assert (clamped) else begin
            $display("paddle 1 never stopped at the screen edge");
            stop_on_error();
        end
        wait_sync(1'b1, 1'b0, n);
        clock_wait(1);
        btn_up = 1'b0;
        btn_dn = 1'b0;
    endtask

    task automatic human_paddle();
        int guard;
        apply_reset();
        btn_ctrl = 1'b1;
        clock_wait(2 * DEB);
        btn_ctrl = 1'b0;
        guard = 0;
        while (u_dut.state != pong_pkg::PLAY) begin
            @(negedge clk_pix);
            guard++;
            if (guard > 4 * DEB) timed_out("the game to enter PLAY");
        end
        hold_paddle(1'b1);
        hold_paddle(1'b0);
    endtask

    task automatic debounce_filter();
        int prev;
        int n;
        next_frame();
        prev = p1_top;
        wait_sync(1'b1, 1'b0, n);
        clock_wait(1);
        repeat (FRAME * 5 / (2 * DEB)) begin  // spans two frame updates
            btn_up = 1'b1;
            clock_wait(DEB / 2);
            btn_up = 1'b0;
            clock_wait(DEB / 2);
        end
        next_frame();
        expect_eq(p1_top, prev, "paddle 1 after short up pulses");
        btn_ctrl = 1'b1;
        clock_wait(DEB / 2);
        btn_ctrl = 1'b0;
        clock_wait(3 * DEB);
        expect_eq(int'(u_dut.state), int'(pong_pkg::PLAY), "game state after ctrl glitch");
    endtask

    initial begin
        reset_state();
        raster_timing();
        idle_motion();
        human_paddle();
        debounce_filter();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- tb.f
logic/pong_pkg.sv
logic/display_timings.sv
logic/button_debounce.sv
logic/paddle_control.sv
logic/ball_motion.sv
logic/pixel_render.sv
logic/pong_top.sv
tests/pong_assertions.sv
tests/pong_tb.sv

//--- run.sh
#!/bin/sh
# build the pong testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pong_tb -f tb.f -o pong_sim
out=$(./obj_dir/pong_sim 2>&1) || true
echo "$out"
echo "$out" | grep -q "^Done: no errors$"
